// File: hdl/aud_macros.svh
`ifndef AUD_MACROS_SVH
`define AUD_MACROS_SVH

// one mono sample
`define AUD_SAMPLE_W      16

// sram depth is 2**AUD_ADDR_W samples
`define AUD_ADDR_W        10

// counts 0..16 serial bits inside a slot
`define AUD_BIT_CNT_W     5

// elapsed time display
`define AUD_TICKS_PER_SEC 64
`define AUD_TICK_W        6
`define AUD_TIME_W        6

`endif

// File: hdl/aud_mode_pkg.sv
`default_nettype none

package aud_mode_pkg;

	// controller state, also shown on o_mode
	typedef enum logic [2:0] {
		MODE_STOP       = 3'd0,
		MODE_REC        = 3'd1,
		MODE_REC_PAUSE  = 3'd2,
		MODE_PLAY       = 3'd3,
		MODE_PLAY_PAUSE = 3'd4
	} aud_mode_e;

	// how the dsp walks through the stored samples
	typedef enum logic [1:0] {
		PB_NORMAL = 2'd0,
		PB_FAST   = 2'd1,
		PB_HOLD   = 2'd2,
		PB_LINEAR = 2'd3
	} pb_kind_e;

	// speed factor is 2**shift
	typedef struct packed {
		pb_kind_e   kind;
		logic [1:0] shift;
	} play_cfg_t;

endpackage

`default_nettype wire

// File: hdl/aud_mem_pkg.sv
`default_nettype none
`include "aud_macros.svh"

package aud_mem_pkg;

	typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

	// recorder side, one cycle strobe
	typedef struct packed {
		logic                   valid;
		logic [`AUD_ADDR_W-1:0] addr;
		sample_t                data;
	} mem_wr_t;

	// dsp side, one cycle strobe
	typedef struct packed {
		logic                   valid;
		logic [`AUD_ADDR_W-1:0] addr;
	} mem_rd_t;

	// read data back to the dsp
	typedef struct packed {
		logic    valid;
		sample_t data;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: hdl/aud_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "aud_macros.svh"

module aud_ctrl
	import aud_mode_pkg::*;
(
	input  wire logic                   i_clk,
	input  wire logic                   i_rst_n,
	input  wire logic                   i_key_rec,
	input  wire logic                   i_key_play,
	input  wire logic                   i_key_stop,
	input  wire logic [1:0]             i_speed,
	input  wire logic                   i_fast,
	input  wire logic                   i_slow_0,
	input  wire logic                   i_slow_1,
	input  wire logic                   i_rec_full,
	input  wire logic                   i_play_done,
	output aud_mode_e                   o_mode,
	output logic                        o_rec_en,
	output logic                        o_play_en,
	output logic                        o_rec_restart,
	output logic                        o_play_restart,
	output play_cfg_t                   o_cfg,
	output logic [`AUD_TIME_W-1:0]      o_rec_time,
	output logic [`AUD_TIME_W-1:0]      o_play_time
);

	// key bit 0 is rec, bit 1 is play and bit 2 is stop
	logic [2:0] key_q1, key_q2, key_rise;
	aud_mode_e mode_r, mode_nxt;
	logic rec_start, play_start;
	// timer index 0 is record and 1 is play
	logic [1:0][`AUD_TICK_W-1:0] tick_r;
	logic [1:0][`AUD_TIME_W-1:0] time_r;
	logic [1:0] time_run, time_clr;

	assign key_rise = key_q1 & ~key_q2;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			key_q1 <= '0;
			key_q2 <= '0;
		end else begin
			key_q1 <= {i_key_stop, i_key_play, i_key_rec};
			key_q2 <= key_q1;
		end
	end

	always_comb begin
		mode_nxt = mode_r;
		case (mode_r)
			MODE_STOP: begin
				if (key_rise[0])
					mode_nxt = MODE_REC;
				else if (key_rise[1])
					mode_nxt = MODE_PLAY;
			end
			MODE_REC: begin
				if (i_rec_full)
					mode_nxt = MODE_STOP;
				else if (key_rise[0])
					mode_nxt = MODE_REC_PAUSE;
			end
			MODE_REC_PAUSE: begin
				if (key_rise[0])
					mode_nxt = MODE_REC;
				else if (key_rise[2])
					mode_nxt = MODE_STOP;
			end
			MODE_PLAY: begin
				if (i_play_done)
					mode_nxt = MODE_STOP;
				else if (key_rise[1])
					mode_nxt = MODE_PLAY_PAUSE;
			end
			MODE_PLAY_PAUSE: begin
				if (key_rise[1])
					mode_nxt = MODE_PLAY;
				else if (key_rise[2])
					mode_nxt = MODE_STOP;
			end
			default: mode_nxt = MODE_STOP;
		endcase
	end

	assign rec_start  = (mode_r == MODE_STOP) && (mode_nxt == MODE_REC);
	assign play_start = (mode_r == MODE_STOP) && (mode_nxt == MODE_PLAY);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode_r         <= MODE_STOP;
			o_rec_restart  <= 1'b0;
			o_play_restart <= 1'b0;
			o_cfg          <= '{kind: PB_NORMAL, shift: 2'd0};
		end else begin
			mode_r         <= mode_nxt;
			o_rec_restart  <= rec_start;
			o_play_restart <= play_start;
			// switches only take effect while stopped
			if (mode_r == MODE_STOP) begin
				o_cfg.shift <= i_speed;
				if (i_fast)
					o_cfg.kind <= PB_FAST;
				else if (i_slow_0)
					o_cfg.kind <= PB_HOLD;
				else if (i_slow_1)
					o_cfg.kind <= PB_LINEAR;
				else
					o_cfg.kind <= PB_NORMAL;
			end
		end
	end

	assign time_run = {mode_r == MODE_PLAY, mode_r == MODE_REC};
	assign time_clr = {play_start, rec_start};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			tick_r <= '0;
			time_r <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (time_clr[i]) begin
					tick_r[i] <= '0;
					time_r[i] <= '0;
				end else if (time_run[i]) begin
					if (tick_r[i] == (`AUD_TICK_W)'(`AUD_TICKS_PER_SEC - 1)) begin
						tick_r[i] <= '0;
						time_r[i] <= time_r[i] + 1'b1;
					end else begin
						tick_r[i] <= tick_r[i] + 1'b1;
					end
				end
			end
		end
	end

	assign o_mode      = mode_r;
	assign o_rec_en    = (mode_r == MODE_REC);
	assign o_play_en   = (mode_r == MODE_PLAY);
	assign o_rec_time  = time_r[0];
	assign o_play_time = time_r[1];

	// a full pulse outside record would leave the recorder stuck
	a_full_in_rec: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_rec_full |-> mode_r == MODE_REC);

endmodule

`default_nettype wire

// File: hdl/aud_recorder.sv
`timescale 1ns/1ps
`default_nettype none
`include "aud_macros.svh"

module aud_recorder
	import aud_mem_pkg::*;
(
	input  wire logic                 i_clk,
	input  wire logic                 i_rst_n,
	input  wire logic                 i_en,
	input  wire logic                 i_restart,
	input  wire logic                 i_lrck,
	input  wire logic                 i_bit_en,
	input  wire logic                 i_adcdat,
	output mem_wr_t                   o_wr,
	output logic [`AUD_ADDR_W:0]      o_rec_len,
	output logic                      o_rec_full
);

	logic lrck_q, lrck_tgl;
	logic [`AUD_BIT_CNT_W-1:0] bit_cnt;
	logic [`AUD_SAMPLE_W-1:0] shreg, sample_in;
	logic shift_in, last_bit, store;
	logic wr_valid;
	logic [`AUD_ADDR_W-1:0] wr_addr;
	sample_t wr_data;

	assign lrck_tgl  = i_lrck ^ lrck_q;
	// a strobe in the toggle cycle belongs to no slot
	assign shift_in  = i_bit_en && !lrck_tgl && (bit_cnt < `AUD_SAMPLE_W);
	assign last_bit  = shift_in && (bit_cnt == `AUD_SAMPLE_W - 1);
	assign sample_in = {shreg[`AUD_SAMPLE_W-2:0], i_adcdat};
	// length msb set means every address is used
	assign store     = last_bit && i_en && !i_restart && !o_rec_len[`AUD_ADDR_W];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrck_q     <= 1'b0;
			bit_cnt    <= '0;
			wr_valid   <= 1'b0;
			o_rec_len  <= '0;
			o_rec_full <= 1'b0;
		end else begin
			lrck_q     <= i_lrck;
			wr_valid   <= store;
			o_rec_full <= store && (&o_rec_len[`AUD_ADDR_W-1:0]);
			if (lrck_tgl)
				bit_cnt <= '0;
			else if (shift_in)
				bit_cnt <= bit_cnt + 1'b1;
			if (i_restart)
				o_rec_len <= '0;
			else if (store)
				o_rec_len <= o_rec_len + 1'b1;
		end
	end

	// sample and write payload
	always_ff @(posedge i_clk) begin
		if (shift_in)
			shreg <= sample_in;
		if (store) begin
			wr_addr <= o_rec_len[`AUD_ADDR_W-1:0];
			wr_data <= sample_in;
		end
	end

	assign o_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

	// writes land on consecutive addresses and stay inside the sram
	a_wr_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_wr.valid |-> (o_rec_len != '0) && ({1'b0, o_wr.addr} == o_rec_len - 1'b1));

endmodule

`default_nettype wire

// File: hdl/aud_dsp.sv
`timescale 1ns/1ps
`default_nettype none
`include "aud_macros.svh"

module aud_dsp
	import aud_mode_pkg::*;
	import aud_mem_pkg::*;
(
	input  wire logic                 i_clk,
	input  wire logic                 i_rst_n,
	input  wire logic                 i_en,
	input  wire logic                 i_restart,
	input  wire play_cfg_t            i_cfg,
	input  wire logic                 i_lrck,
	input  wire logic [`AUD_ADDR_W:0] i_rec_len,
	input  wire mem_rsp_t             i_rsp,
	output mem_rd_t                   o_rd,
	output sample_t                   o_sample,
	output logic                      o_play_done
);

	typedef enum logic [1:0] {
		F_IDLE = 2'd0,
		F_PREV = 2'd1,
		F_NEXT = 2'd2
	} fetch_e;

	fetch_e fetch_r;
	logic lrck_q, lrck_tgl, wrap;
	logic [`AUD_ADDR_W:0] idx_r, step, idx_adv, idx_nxt;
	logic [2:0] k_r, k_max;
	sample_t prev_r, next_r;
	logic signed [`AUD_SAMPLE_W:0] diff;
	logic signed [`AUD_SAMPLE_W+4:0] prod, interp;

	assign lrck_tgl = i_lrck ^ lrck_q;

	always_comb begin
		// hold and linear stay on one source sample for 2^shift slots
		if (i_cfg.kind == PB_HOLD || i_cfg.kind == PB_LINEAR)
			k_max = (3'd1 << i_cfg.shift) - 3'd1;
		else
			k_max = 3'd0;
		if (i_cfg.kind == PB_FAST)
			step = (`AUD_ADDR_W+1)'(1) << i_cfg.shift;
		else
			step = (`AUD_ADDR_W+1)'(1);
		wrap    = (k_r == k_max);
		idx_adv = idx_r + step;
		idx_nxt = idx_r + 1'b1;
	end

	// prev + ((next - prev) * k) >>> shift
	always_comb begin
		diff   = next_r - prev_r;
		prod   = diff * $signed({1'b0, k_r});
		interp = prev_r + (prod >>> i_cfg.shift);
	end

	assign o_sample = (i_cfg.kind == PB_LINEAR) ? interp[`AUD_SAMPLE_W-1:0] : prev_r;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrck_q      <= 1'b0;
			fetch_r     <= F_IDLE;
			idx_r       <= '0;
			k_r         <= '0;
			prev_r      <= '0;
			next_r      <= '0;
			o_rd        <= '0;
			o_play_done <= 1'b0;
		end else begin
			lrck_q      <= i_lrck;
			o_rd.valid  <= 1'b0;
			o_play_done <= 1'b0;
			if (i_restart) begin
				idx_r  <= '0;
				k_r    <= '0;
				prev_r <= '0;
				next_r <= '0;
				if (i_rec_len == '0) begin
					o_play_done <= 1'b1;
					fetch_r     <= F_IDLE;
				end else begin
					o_rd    <= '{valid: 1'b1, addr: '0};
					fetch_r <= F_PREV;
				end
			end else if (i_rsp.valid) begin
				if (fetch_r == F_PREV) begin
					prev_r <= i_rsp.data;
					if (i_cfg.kind == PB_LINEAR && idx_nxt < i_rec_len) begin
						o_rd    <= '{valid: 1'b1, addr: idx_nxt[`AUD_ADDR_W-1:0]};
						fetch_r <= F_NEXT;
					end else begin
						// last sample ramps toward itself
						next_r  <= i_rsp.data;
						fetch_r <= F_IDLE;
					end
				end else begin
					next_r  <= i_rsp.data;
					fetch_r <= F_IDLE;
				end
			end else if (i_en && lrck_tgl && fetch_r == F_IDLE) begin
				// toggles during an outstanding fetch do not advance
				if (!wrap) begin
					k_r <= k_r + 1'b1;
				end else begin
					k_r   <= '0;
					idx_r <= idx_adv;
					if (idx_adv >= i_rec_len) begin
						o_play_done <= 1'b1;
					end else begin
						o_rd    <= '{valid: 1'b1, addr: idx_adv[`AUD_ADDR_W-1:0]};
						fetch_r <= F_PREV;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/aud_player.sv
`timescale 1ns/1ps
`default_nettype none
`include "aud_macros.svh"

module aud_player
	import aud_mem_pkg::*;
(
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire logic    i_en,
	input  wire logic    i_lrck,
	input  wire logic    i_bit_en,
	input  wire sample_t i_sample,
	output logic         o_dacdat
);

	logic lrck_q;
	logic [`AUD_SAMPLE_W-1:0] shreg;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lrck_q <= 1'b0;
			shreg  <= '0;
		end else begin
			lrck_q <= i_lrck;
			// load wins over a coincident bit strobe
			if (i_lrck ^ lrck_q)
				shreg <= i_en ? i_sample : '0;
			else if (i_bit_en)
				shreg <= {shreg[`AUD_SAMPLE_W-2:0], 1'b0};
		end
	end

	// msb first
	assign o_dacdat = shreg[`AUD_SAMPLE_W-1];

endmodule

`default_nettype wire

// File: hdl/aud_sram_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "aud_macros.svh"

module aud_sram_port
	import aud_mem_pkg::*;
(
	input  wire logic                     i_clk,
	input  wire logic                     i_rst_n,
	input  wire mem_wr_t                  i_wr,
	input  wire mem_rd_t                  i_rd,
	input  wire logic [`AUD_SAMPLE_W-1:0] i_sram_rdata,
	output logic [`AUD_ADDR_W-1:0]        o_sram_addr,
	output logic [`AUD_SAMPLE_W-1:0]      o_sram_wdata,
	output logic                          o_sram_we_n,
	output mem_rsp_t                      o_rsp
);

	logic rd_pend, rsp_valid;
	sample_t rsp_data;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sram_we_n <= 1'b1;
			rd_pend     <= 1'b0;
			rsp_valid   <= 1'b0;
		end else begin
			o_sram_we_n <= !i_wr.valid;
			rd_pend     <= i_rd.valid;
			rsp_valid   <= rd_pend;
		end
	end

	// pins hold the last request until the next one
	always_ff @(posedge i_clk) begin
		if (i_wr.valid) begin
			o_sram_addr  <= i_wr.addr;
			o_sram_wdata <= i_wr.data;
		end else if (i_rd.valid) begin
			o_sram_addr <= i_rd.addr;
		end
		if (rd_pend)
			rsp_data <= i_sram_rdata;
	end

	assign o_rsp = '{valid: rsp_valid, data: rsp_data};

	// recorder and dsp requests never collide
	a_no_collide: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_wr.valid && i_rd.valid));

endmodule

`default_nettype wire

// File: hdl/aud_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "aud_macros.svh"

module aud_top
	import aud_mode_pkg::*;
	import aud_mem_pkg::*;
(
	input  wire logic                     i_clk,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_key_rec,
	input  wire logic                     i_key_play,
	input  wire logic                     i_key_stop,
	input  wire logic [1:0]               i_speed,
	input  wire logic                     i_fast,
	input  wire logic                     i_slow_0,
	input  wire logic                     i_slow_1,
	input  wire logic                     i_lrck,
	input  wire logic                     i_bit_en,
	input  wire logic                     i_adcdat,
	output logic                          o_dacdat,
	output logic [`AUD_ADDR_W-1:0]        o_sram_addr,
	output logic [`AUD_SAMPLE_W-1:0]      o_sram_wdata,
	output logic                          o_sram_we_n,
	input  wire logic [`AUD_SAMPLE_W-1:0] i_sram_rdata,
	output logic [`AUD_TIME_W-1:0]        o_rec_time,
	output logic [`AUD_TIME_W-1:0]        o_play_time,
	output aud_mode_e                     o_mode
);

	logic rec_en, play_en, rec_restart, play_restart;
	logic rec_full, play_done;
	play_cfg_t cfg;
	logic [`AUD_ADDR_W:0] rec_len;
	mem_wr_t wr;
	mem_rd_t rd;
	mem_rsp_t rsp;
	sample_t play_sample;

	aud_ctrl u_ctrl (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_key_rec      (i_key_rec),
		.i_key_play     (i_key_play),
		.i_key_stop     (i_key_stop),
		.i_speed        (i_speed),
		.i_fast         (i_fast),
		.i_slow_0       (i_slow_0),
		.i_slow_1       (i_slow_1),
		.i_rec_full     (rec_full),
		.i_play_done    (play_done),
		.o_mode         (o_mode),
		.o_rec_en       (rec_en),
		.o_play_en      (play_en),
		.o_rec_restart  (rec_restart),
		.o_play_restart (play_restart),
		.o_cfg          (cfg),
		.o_rec_time     (o_rec_time),
		.o_play_time    (o_play_time)
	);

	aud_recorder u_recorder (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_en       (rec_en),
		.i_restart  (rec_restart),
		.i_lrck     (i_lrck),
		.i_bit_en   (i_bit_en),
		.i_adcdat   (i_adcdat),
		.o_wr       (wr),
		.o_rec_len  (rec_len),
		.o_rec_full (rec_full)
	);

	aud_dsp u_dsp (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_en        (play_en),
		.i_restart   (play_restart),
		.i_cfg       (cfg),
		.i_lrck      (i_lrck),
		.i_rec_len   (rec_len),
		.i_rsp       (rsp),
		.o_rd        (rd),
		.o_sample    (play_sample),
		.o_play_done (play_done)
	);

	aud_player u_player (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_en     (play_en),
		.i_lrck   (i_lrck),
		.i_bit_en (i_bit_en),
		.i_sample (play_sample),
		.o_dacdat (o_dacdat)
	);

	aud_sram_port u_sram_port (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_wr         (wr),
		.i_rd         (rd),
		.i_sram_rdata (i_sram_rdata),
		.o_sram_addr  (o_sram_addr),
		.o_sram_wdata (o_sram_wdata),
		.o_sram_we_n  (o_sram_we_n),
		.o_rsp        (rsp)
	);

endmodule

`default_nettype wire

// File: verif/tb_aud_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "aud_macros.svh"

module tb_aud_top
	import aud_mode_pkg::*;
	import aud_mem_pkg::*;
;

	localparam int SLOT_CYC = 40;
	localparam int DEPTH = 1 << `AUD_ADDR_W;

	logic i_clk, i_rst_n;
	logic i_key_rec, i_key_play, i_key_stop;
	logic [1:0] i_speed;
	logic i_fast, i_slow_0, i_slow_1;
	logic i_lrck, i_bit_en, i_adcdat;
	logic o_dacdat;
	logic [`AUD_ADDR_W-1:0] o_sram_addr;
	logic [`AUD_SAMPLE_W-1:0] o_sram_wdata, i_sram_rdata;
	logic o_sram_we_n;
	logic [`AUD_TIME_W-1:0] o_rec_time, o_play_time;
	aud_mode_e o_mode;

	logic [15:0] sram [DEPTH];
	logic [31:0] rng;
	logic [15:0] rec_q[$];
	logic [15:0] exp_q[$];
	logic [15:0] got_q[$];
	int err_count, check_count, test_count, test_errs;

	aud_top dut (.*);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// sram model written from the pins and read combinationally
	always @(posedge i_clk) begin
		if (!o_sram_we_n)
			sram[o_sram_addr] <= o_sram_wdata;
	end
	assign i_sram_rdata = sram[o_sram_addr];

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare(input string what, input int got, input int exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERROR %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// one lrck slot with the rec key in bit 0, play in bit 1 and stop in bit 2
	task automatic run_slot(input logic [15:0] smp, input logic [2:0] keys,
			output logic [15:0] dac_word, output logic play_seen, output aud_mode_e end_mode);
		for (int c = 0; c < SLOT_CYC; c++) begin
			@(negedge i_clk);
			if (c == 1)
				play_seen = (o_mode == MODE_PLAY);
			if (c >= 2 && c <= 32 && c % 2 == 0)
				dac_word[15 - (c - 2) / 2] = o_dacdat;
			if (c == SLOT_CYC - 1)
				end_mode = o_mode;
			@(posedge i_clk);
			if (c == 0) begin
				i_lrck     <= ~i_lrck;
				i_key_rec  <= keys[0];
				i_key_play <= keys[1];
				i_key_stop <= keys[2];
			end
			if (c == 10) begin
				i_key_rec  <= 1'b0;
				i_key_play <= 1'b0;
				i_key_stop <= 1'b0;
			end
			i_bit_en <= (c % 2 == 1) && (c <= 31);
			i_adcdat <= (c % 2 == 1 && c <= 31) ? smp[15 - (c - 1) / 2] : 1'b0;
		end
	endtask

	task automatic idle_slot(input logic [2:0] keys);
		logic [15:0] w;
		logic p;
		aud_mode_e m;
		rng = xorshift(rng);
		run_slot(rng[15:0], keys, w, p, m);
	endtask

	// sends one random sample and keeps it in the model when it should be stored
	task automatic rec_slot(input logic [2:0] keys, input bit keep, output aud_mode_e m);
		logic [15:0] w;
		logic p;
		rng = xorshift(rng);
		if (keep)
			rec_q.push_back(rng[15:0]);
		run_slot(rng[15:0], keys, w, p, m);
	endtask

	function automatic void build_expected(input pb_kind_e kind, input int sh);
		int len, p, n, reps;
		logic [31:0] v;
		len = rec_q.size();
		reps = (kind == PB_HOLD || kind == PB_LINEAR) ? (1 << sh) : 1;
		exp_q.delete();
		for (int i = 0; i < len; i++) begin
			if (kind == PB_FAST && i % (1 << sh) != 0)
				continue;
			for (int k = 0; k < reps; k++) begin
				p = $signed(rec_q[i]);
				n = (i + 1 < len) ? $signed(rec_q[i + 1]) : p;
				// midpoint steps toward the next sample
				v = (kind == PB_LINEAR) ? p + (((n - p) * k) >>> sh) : p;
				exp_q.push_back(v[15:0]);
			end
		end
	endfunction

	task automatic check_sram(input string what);
		for (int a = 0; a < rec_q.size(); a++)
			compare($sformatf("%s sram[%0d]", what, a), sram[a], rec_q[a]);
	endtask

	task automatic set_cfg(input bit fast, input bit s0, input bit s1, input logic [1:0] sh);
		@(posedge i_clk);
		i_fast   <= fast;
		i_slow_0 <= s0;
		i_slow_1 <= s1;
		i_speed  <= sh;
	endtask

	// plays the recording and pauses after pause_at output slots when nonzero
	task automatic play_run(input string what, input pb_kind_e kind, input int sh,
			input int pause_at);
		logic [15:0] w;
		logic p;
		aud_mode_e m;
		int n;
		build_expected(kind, sh);
		got_q.delete();
		run_slot(16'h0, 3'b010, w, p, m);
		n = 0;
		m = MODE_PLAY;
		while (m != MODE_STOP && n < 5000) begin
			if (pause_at > 0 && got_q.size() == pause_at) begin
				run_slot(16'h0, 3'b010, w, p, m);
				if (p)
					got_q.push_back(w);
				for (int i = 0; i < 4; i++) begin
					run_slot(16'h0, 3'b000, w, p, m);
					compare({what, " output while paused"}, w, 0);
				end
				run_slot(16'h0, 3'b010, w, p, m);
				pause_at = 0;
			end else begin
				run_slot(16'h0, 3'b000, w, p, m);
			end
			if (p)
				got_q.push_back(w);
			n++;
		end
		if (n >= 5000) begin
			err_count++;
			$display("timeout: %s playback never returned to stop", what);
		end
		compare({what, " sample count"}, got_q.size(), exp_q.size());
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
			compare($sformatf("%s word %0d", what, i), got_q[i], exp_q[i]);
	endtask

	task automatic check_time(input string what, input int got, input int active_cyc);
		int exp;
		exp = active_cyc / `AUD_TICKS_PER_SEC;
		// one step of slack for where the tick counter sits
		compare($sformatf("%s time %0d within one step of %0d", what, got, exp),
			(got >= exp - 1 && got <= exp + 1), 1);
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == test_errs)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, err_count - test_errs);
		test_errs = err_count;
	endtask

	initial begin
		aud_mode_e m;
		int n;
		i_rst_n = 1'b0;
		i_key_rec = 1'b0;
		i_key_play = 1'b0;
		i_key_stop = 1'b0;
		i_speed = 2'd0;
		i_fast = 1'b0;
		i_slow_0 = 1'b0;
		i_slow_1 = 1'b0;
		i_lrck = 1'b0;
		i_bit_en = 1'b0;
		i_adcdat = 1'b0;
		rng = 32'd92286;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		test_errs = 0;
		for (int a = 0; a < DEPTH; a++)
			sram[a] = 16'(a * 40503) ^ 16'h5a5a;
		repeat (16) @(posedge i_clk);
		i_rst_n <= 1'b1;

		@(negedge i_clk);
		compare("reset mode", o_mode, MODE_STOP);
		compare("reset we_n", o_sram_we_n, 1);
		compare("reset rec time", o_rec_time, 0);
		compare("reset play time", o_play_time, 0);
		compare("reset dacdat", o_dacdat, 0);
		rec_slot(3'b001, 1, m);
		for (int i = 1; i < 40; i++)
			rec_slot(3'b000, 1, m);
		idle_slot(3'b001);
		idle_slot(3'b100);
		compare("mode after record", o_mode, MODE_STOP);
		check_sram("record");
		end_test("record");

		set_cfg(0, 0, 0, 2'd0);
		play_run("normal", PB_NORMAL, 0, 0);
		end_test("normal play");

		set_cfg(1, 0, 0, 2'd1);
		play_run("fast", PB_FAST, 1, 0);
		set_cfg(0, 1, 0, 2'd2);
		play_run("hold", PB_HOLD, 2, 0);
		end_test("fast and hold play");

		set_cfg(0, 0, 1, 2'd1);
		play_run("linear", PB_LINEAR, 1, 0);
		end_test("linear play");

		// 10 samples then a pause then 14 more samples
		rec_q.delete();
		rec_slot(3'b001, 1, m);
		for (int i = 1; i < 10; i++)
			rec_slot(3'b000, 1, m);
		idle_slot(3'b001);
		for (int i = 0; i < 4; i++)
			idle_slot(3'b000);
		rec_slot(3'b001, 1, m);
		for (int i = 1; i < 14; i++)
			rec_slot(3'b000, 1, m);
		idle_slot(3'b001);
		idle_slot(3'b100);
		@(negedge i_clk);
		check_time("record", o_rec_time, 24 * SLOT_CYC);
		check_sram("paused record");
		set_cfg(0, 0, 0, 2'd0);
		play_run("paused play", PB_NORMAL, 0, 7);
		@(negedge i_clk);
		check_time("play", o_play_time, 24 * SLOT_CYC);
		end_test("pause and resume");

		rec_q.delete();
		rec_slot(3'b001, 1, m);
		n = 1;
		while (m != MODE_STOP && n < 1100) begin
			rec_slot(3'b000, 1, m);
			n++;
		end
		if (n >= 1100) begin
			err_count++;
			$display("timeout: recording never stopped at memory full");
		end
		compare("samples until full", n, DEPTH);
		while (rec_q.size() > DEPTH)
			void'(rec_q.pop_back());
		check_sram("full");
		end_test("memory full");

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/aud_mode_pkg.sv
hdl/aud_mem_pkg.sv
hdl/aud_ctrl.sv
hdl/aud_recorder.sv
hdl/aud_dsp.sv
hdl/aud_player.sv
hdl/aud_sram_port.sv
hdl/aud_top.sv
verif/tb_aud_top.sv
